//--- src/link_pkg.sv
`default_nettype none

package link_pkg;

	localparam int PACKET_BITS = 4;
	localparam int BIT_CNT_W = $clog2(PACKET_BITS);
	localparam int QSEL_W = 2;
	localparam int PAYLOAD_W = PACKET_BITS - QSEL_W;

	// Line symbol as {line_hi, line_lo}
	typedef enum logic [1:0] {
		sym_idle = 2'b00,
		sym_one  = 2'b01, // Low wire alone
		sym_zero = 2'b10, // High wire alone
		sym_sep  = 2'b11
	} line_sym_t;

	typedef enum logic [1:0] {
		rx_disarmed = 2'd0,
		rx_wait_bit = 2'd1,
		rx_wait_sep = 2'd2
	} rx_state_t;

	// First received bit lands in queue_sel[1]
	typedef struct packed {
		logic [QSEL_W-1:0]    queue_sel;
		logic [PAYLOAD_W-1:0] payload;
	} packet_t;

endpackage

`default_nettype wire

//--- src/buffer_pkg.sv
`default_nettype none

package buffer_pkg;

	localparam int NUM_QUEUES = 4;
	localparam int QUEUE_DEPTH = 6;
	localparam int SLOT_W = 3;
	localparam int OCC_W = 3;
	localparam int DROP_W = 7;
	localparam int DIGIT_W = 4;
	localparam int DROP_MAX = 99;

	// Wide enough for four saturated counts
	localparam int DROP_SUM_W = DROP_W + $clog2(NUM_QUEUES);

	// Top bit set marks an empty slot
	typedef logic [SLOT_W-1:0] slot_t;

	localparam slot_t SLOT_EMPTY = 3'd7;

	// Index 0 is the newest slot
	typedef slot_t [QUEUE_DEPTH-1:0] queue_t;

	typedef logic [OCC_W-1:0] occ_t;

	typedef logic [DROP_W-1:0] drop_t;

	typedef struct packed {
		logic [DIGIT_W-1:0] tens;
		logic [DIGIT_W-1:0] ones;
	} dec_pair_t;

	typedef struct packed {
		queue_t slots;
		occ_t   occupancy;
	} queue_status_t;

endpackage

`default_nettype wire

//--- src/packet_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module packet_receiver import link_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    start,
	input  logic    line_hi,
	input  logic    line_lo,
	output logic    armed,
	output packet_t pkt,
	output logic    pkt_valid
);

	rx_state_t state;
	line_sym_t sym;
	logic [BIT_CNT_W-1:0] bit_cnt;
	logic [PACKET_BITS-2:0] bits_q; // Earlier bits, first one on top
	logic bit_seen;
	logic bit_value;
	logic take_bit;
	logic last_bit;

	assign sym = line_sym_t'({line_hi, line_lo});

	assign bit_seen = (sym == sym_zero) || (sym == sym_one);
	assign bit_value = (sym == sym_one);

	// A bit only counts right after a separator
	assign take_bit = (state == rx_wait_bit) && bit_seen;
	assign last_bit = take_bit && (bit_cnt == BIT_CNT_W'(PACKET_BITS - 1));

	assign armed = (state != rx_disarmed);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= rx_disarmed;
			bit_cnt <= '0;
			pkt_valid <= 1'b0;
		end else begin
			pkt_valid <= last_bit; // Single cycle strobe
			case (state)
				rx_disarmed: begin
					if (start) begin
						state <= rx_wait_bit;
						bit_cnt <= '0;
					end
				end
				rx_wait_bit: begin
					if (bit_seen) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (last_bit) begin
							state <= rx_disarmed;
						end else begin
							state <= rx_wait_sep;
						end
					end
				end
				rx_wait_sep: begin
					if (sym == sym_sep) begin
						state <= rx_wait_bit;
					end
				end
				default: begin
					state <= rx_disarmed;
				end
			endcase
		end
	end

	// Shift in MSB first, capture on the fourth bit
	always_ff @(posedge clk) begin
		if (take_bit) begin
			bits_q <= {bits_q[PACKET_BITS-3:0], bit_value};
		end
		if (last_bit) begin
			pkt <= packet_t'({bits_q, bit_value});
		end
	end

endmodule

`default_nettype wire

//--- src/buffer_bank.sv
`timescale 1ns/1ps
`default_nettype none

module buffer_bank import link_pkg::*, buffer_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	input  packet_t       pkt,
	input  logic          pkt_valid,
	output queue_status_t status [NUM_QUEUES],
	output drop_t         drop_counts [NUM_QUEUES],
	output logic          drops_valid
);

	queue_t slots_q [NUM_QUEUES];
	occ_t occ_q [NUM_QUEUES];
	drop_t drop_q [NUM_QUEUES];
	queue_t slots_next [NUM_QUEUES];
	logic [NUM_QUEUES-1:0] hit;
	logic [NUM_QUEUES-1:0] overflow;
	slot_t new_slot;

	function automatic occ_t count_occupied(queue_t q);
		occ_t n;
		n = '0;
		for (int s = 0; s < QUEUE_DEPTH; s++) begin
			if (!q[s][SLOT_W-1]) begin
				n = n + 1'b1;
			end
		end
		return n;
	endfunction

	assign new_slot = slot_t'({1'b0, pkt.payload});

	always_comb begin
		for (int i = 0; i < NUM_QUEUES; i++) begin
			hit[i] = pkt_valid && (pkt.queue_sel == QSEL_W'(i));
			// Oldest slot falls off the far end
			slots_next[i] = {slots_q[i][QUEUE_DEPTH-2:0], new_slot};
			overflow[i] = !slots_q[i][QUEUE_DEPTH-1][SLOT_W-1];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_QUEUES; i++) begin
				slots_q[i] <= {QUEUE_DEPTH{SLOT_EMPTY}};
				occ_q[i] <= '0;
				drop_q[i] <= '0;
			end
			drops_valid <= 1'b0;
		end else begin
			drops_valid <= pkt_valid;
			for (int i = 0; i < NUM_QUEUES; i++) begin
				if (hit[i]) begin
					slots_q[i] <= slots_next[i];
					occ_q[i] <= count_occupied(slots_next[i]);
					if (overflow[i] && (drop_q[i] != drop_t'(DROP_MAX))) begin
						drop_q[i] <= drop_q[i] + 1'b1; // Stops at 99
					end
				end
			end
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_QUEUES; i++) begin
			status[i].slots = slots_q[i];
			status[i].occupancy = occ_q[i];
			drop_counts[i] = drop_q[i];
		end
	end

endmodule

`default_nettype wire

//--- src/drop_statistics.sv
`timescale 1ns/1ps
`default_nettype none

module drop_statistics import buffer_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  drop_t     drop_counts [NUM_QUEUES],
	input  logic      drops_valid,
	output dec_pair_t queue_digits [NUM_QUEUES],
	output dec_pair_t total_digits
);

	logic [DROP_SUM_W-1:0] sum;
	drop_t total;

	// Counts never pass 99, so two digits suffice
	function automatic dec_pair_t to_dec(drop_t v);
		dec_pair_t d;
		d.tens = DIGIT_W'(v / 10);
		d.ones = DIGIT_W'(v % 10);
		return d;
	endfunction

	always_comb begin
		sum = '0;
		for (int i = 0; i < NUM_QUEUES; i++) begin
			sum = sum + DROP_SUM_W'(drop_counts[i]);
		end
		if (sum > DROP_SUM_W'(DROP_MAX)) begin
			total = drop_t'(DROP_MAX);
		end else begin
			total = drop_t'(sum);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_QUEUES; i++) begin
				queue_digits[i] <= '0;
			end
			total_digits <= '0;
		end else if (drops_valid) begin
			for (int i = 0; i < NUM_QUEUES; i++) begin
				queue_digits[i] <= to_dec(drop_counts[i]);
			end
			total_digits <= to_dec(total);
		end
	end

endmodule

`default_nettype wire

//--- src/packet_switch_top.sv
`timescale 1ns/1ps
`default_nettype none

module packet_switch_top import link_pkg::*, buffer_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	input  logic          start,
	input  logic          line_hi,
	input  logic          line_lo,
	output logic          armed,
	output queue_status_t status [NUM_QUEUES],
	output dec_pair_t     queue_digits [NUM_QUEUES],
	output dec_pair_t     total_digits
);

	packet_t pkt;
	logic pkt_valid;
	drop_t drop_counts [NUM_QUEUES];
	logic drops_valid;

	packet_receiver u_receiver (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.line_hi   (line_hi),
		.line_lo   (line_lo),
		.armed     (armed),
		.pkt       (pkt),
		.pkt_valid (pkt_valid)
	);

	// Queues update one edge after the packet strobe
	buffer_bank u_bank (
		.clk         (clk),
		.rst         (rst),
		.pkt         (pkt),
		.pkt_valid   (pkt_valid),
		.status      (status),
		.drop_counts (drop_counts),
		.drops_valid (drops_valid)
	);

	drop_statistics u_stats (
		.clk          (clk),
		.rst          (rst),
		.drop_counts  (drop_counts),
		.drops_valid  (drops_valid),
		.queue_digits (queue_digits),
		.total_digits (total_digits)
	);

endmodule

`default_nettype wire

//--- verification/packet_switch_assert.sv
`timescale 1ns/1ps
`default_nettype none

module packet_switch_assert import buffer_pkg::*; #(
	parameter bit RX_SIDE = 1'b0 // Receiver checks instead of queue checks
) (
	input logic          clk,
	input logic          rst,
	input logic          pkt_valid,
	input logic          armed,
	input queue_status_t qs
);

	int fail_count = 0;

	// Codes 4 to 6 are neither a payload nor the empty code
	function automatic logic codes_valid(queue_t q);
		for (int s = 0; s < QUEUE_DEPTH; s++) begin
			if (q[s] >= slot_t'(4) && q[s] <= slot_t'(6)) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	if (RX_SIDE) begin : g_rx
		strobe_single: assert property (@(posedge clk) disable iff (rst)
			pkt_valid |=> !pkt_valid)
			else begin
				fail_count++;
				$error("pkt_valid stayed high for two cycles");
			end

		disarm_on_reset: assert property (@(posedge clk) rst |=> !armed)
			else begin
				fail_count++;
				$error("receiver armed in the cycle after reset");
			end
	end else begin : g_queue
		occupancy_bound: assert property (@(posedge clk) disable iff (rst)
			qs.occupancy <= occ_t'(QUEUE_DEPTH))
			else begin
				fail_count++;
				$error("queue occupancy above the queue depth");
			end

		slot_codes: assert property (@(posedge clk) disable iff (rst) codes_valid(qs.slots))
			else begin
				fail_count++;
				$error("a queue slot holds a reserved code");
			end
	end

endmodule

bind packet_receiver packet_switch_assert #(.RX_SIDE(1'b1)) rx_props (
	.clk(clk), .rst(rst), .pkt_valid(pkt_valid), .armed(armed), .qs('0)
);
bind buffer_bank packet_switch_assert q0_props (
	.clk(clk), .rst(rst), .pkt_valid(pkt_valid), .armed(1'b0), .qs(status[0])
);
bind buffer_bank packet_switch_assert q1_props (
	.clk(clk), .rst(rst), .pkt_valid(pkt_valid), .armed(1'b0), .qs(status[1])
);
bind buffer_bank packet_switch_assert q2_props (
	.clk(clk), .rst(rst), .pkt_valid(pkt_valid), .armed(1'b0), .qs(status[2])
);
bind buffer_bank packet_switch_assert q3_props (
	.clk(clk), .rst(rst), .pkt_valid(pkt_valid), .armed(1'b0), .qs(status[3])
);

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst,
	input  logic restart
);

	localparam int RESET_CYCLES = 4;

	int rst_left = RESET_CYCLES;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	always @(posedge clk) begin
		if (restart) begin
			rst_left <= RESET_CYCLES;
		end else if (rst_left > 0) begin
			rst_left <= rst_left - 1;
		end
	end

	assign rst = (rst_left != 0); // High for four rising edges

endmodule

`default_nettype wire

//--- verification/tb_packet_switch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_packet_switch import link_pkg::*, buffer_pkg::*; ();

	localparam int VEC_FIELDS = 5;
	localparam int MAX_VECTORS = 32;
	localparam int WAIT_LIMIT = 60;
	localparam int RANDOM_PACKETS = 130;

	logic clk;
	logic rst;
	logic restart;
	logic start;
	logic line_hi;
	logic line_lo;
	logic armed;
	queue_status_t status [NUM_QUEUES];
	dec_pair_t queue_digits [NUM_QUEUES];
	dec_pair_t total_digits;

	logic [19:0] vec_mem [0:VEC_FIELDS*MAX_VECTORS-1];
	queue_t exp_slots [NUM_QUEUES];
	occ_t exp_occ [NUM_QUEUES];
	int exp_drops [NUM_QUEUES];
	logic [31:0] lfsr;
	int errors;
	int timeouts;
	int assert_fails;

	tb_clock_gen clock_gen (.clk(clk), .rst(rst), .restart(restart));

	packet_switch_top DUT (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.line_hi      (line_hi),
		.line_lo      (line_lo),
		.armed        (armed),
		.status       (status),
		.queue_digits (queue_digits),
		.total_digits (total_digits)
	);

	function automatic logic take_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) begin
			lfsr = lfsr ^ 32'h8020_0003; // Taps 32, 22, 2, 1
		end
		return b;
	endfunction

	function automatic int dec_code(input int n);
		return (n / 10) * 16 + (n % 10);
	endfunction

	function automatic void clear_expected();
		for (int q = 0; q < NUM_QUEUES; q++) begin
			exp_slots[q] = {QUEUE_DEPTH{SLOT_EMPTY}};
			exp_occ[q] = '0;
			exp_drops[q] = 0;
		end
	endfunction

	function automatic void push_expected(input int q, input int p);
		if (exp_occ[q] == occ_t'(QUEUE_DEPTH) && exp_drops[q] < DROP_MAX) begin
			exp_drops[q]++; // Full queue loses its oldest
		end
		if (exp_occ[q] != occ_t'(QUEUE_DEPTH)) begin
			exp_occ[q] = exp_occ[q] + 1'b1; // Payloads always occupy
		end
		exp_slots[q] = {exp_slots[q][QUEUE_DEPTH-2:0], slot_t'(p)};
	endfunction

	task automatic check_val(input string name, input int expected, input int actual);
		assert (expected == actual) else begin
			errors++;
			$display("ERR %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic check_all(input string tag);
		int total;
		total = 0;
		for (int q = 0; q < NUM_QUEUES; q++) begin
			check_val($sformatf("%s q%0d slots", tag, q),
				int'(exp_slots[q]), int'(status[q].slots));
			check_val($sformatf("%s q%0d occupancy", tag, q),
				int'(exp_occ[q]), int'(status[q].occupancy));
			check_val($sformatf("%s q%0d drop digits", tag, q),
				dec_code(exp_drops[q]), int'(queue_digits[q]));
			total += exp_drops[q];
		end
		if (total > DROP_MAX) begin
			total = DROP_MAX;
		end
		check_val($sformatf("%s total digits", tag), dec_code(total), int'(total_digits));
	endtask

	task automatic drive_sym(input line_sym_t s);
		@(posedge clk);
		#2;
		{line_hi, line_lo} = s;
	endtask

	task automatic send_bit(input logic b);
		drive_sym(b ? sym_one : sym_zero);
		drive_sym(sym_sep);
		drive_sym(sym_idle);
	endtask

	task automatic arm_receiver();
		@(posedge clk);
		#2;
		start = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
	endtask

	task automatic send_packet(input int q, input int p);
		logic [3:0] bits;
		bits = {2'(q), 2'(p)};
		arm_receiver();
		for (int i = PACKET_BITS - 1; i >= 0; i--) begin
			send_bit(bits[i]); // Queue select first, MSB first
		end
	endtask

	task automatic wait_disarmed();
		int n;
		n = 0;
		while (armed && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (armed) begin
			timeouts++;
			$display("Timeout: receiver still armed after %0d cycles", WAIT_LIMIT);
		end
		repeat (5) @(negedge clk);
	endtask

	task automatic wait_reset_done();
		int n;
		n = 0;
		while (rst && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (rst) begin
			timeouts++;
			$display("Timeout: reset never released");
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#2;
		restart = 1'b1;
		@(posedge clk);
		#2;
		restart = 1'b0;
		wait_reset_done();
	endtask

	initial begin
		int qsel;
		int pay;
		int base;
		logic hi;
		logic lo;
		restart = 1'b0;
		start = 1'b0;
		line_hi = 1'b0;
		line_lo = 1'b0;
		errors = 0;
		timeouts = 0;
		lfsr = 32'h47d5;
		clear_expected();
		$readmemh("verification/packet_vectors.mem", vec_mem);
		wait_reset_done();
		check_all("reset");

		for (int v = 0; v < MAX_VECTORS; v++) begin
			base = v * VEC_FIELDS;
			if (vec_mem[base] > 20'h3) begin
				break; // End marker
			end
			qsel = int'(vec_mem[base]);
			send_packet(qsel, int'(vec_mem[base + 1]));
			wait_disarmed();
			exp_slots[qsel] = vec_mem[base + 2][17:0];
			exp_occ[qsel] = vec_mem[base + 3][2:0];
			exp_drops[qsel] = int'(vec_mem[base + 4][7:4]) * 10 + int'(vec_mem[base + 4][3:0]);
			check_all($sformatf("vector %0d", v));
		end

		for (int i = 0; i < PACKET_BITS; i++) begin
			send_bit(1'b1); // No start, so nothing arms
		end
		wait_disarmed();
		check_val("disarmed armed", 0, int'(armed));
		check_all("disarmed");

		arm_receiver();
		drive_sym(sym_zero);
		drive_sym(sym_one); // No separator yet
		drive_sym(sym_idle);
		drive_sym(sym_sep);
		drive_sym(sym_idle);
		send_bit(1'b0);
		send_bit(1'b1);
		check_val("protocol still armed", 1, int'(armed));
		send_bit(1'b1);
		wait_disarmed();
		push_expected(0, 3);
		check_all("protocol");

		apply_reset();
		clear_expected();
		for (int n = 0; n < RANDOM_PACKETS; n++) begin
			hi = take_bit();
			lo = take_bit();
			qsel = int'({hi, lo});
			hi = take_bit();
			lo = take_bit();
			pay = int'({hi, lo});
			send_packet(qsel, pay);
			wait_disarmed();
			push_expected(qsel, pay);
		end
		check_all("random");
		check_val("random total saturated", 32'h99, int'(total_digits));
		for (int q = 0; q < NUM_QUEUES; q++) begin
			if (exp_drops[q] > 0) begin
				check_val($sformatf("random q%0d full", q), QUEUE_DEPTH, int'(status[q].occupancy));
			end
		end

		assert_fails = DUT.u_receiver.rx_props.fail_count + DUT.u_bank.q0_props.fail_count
			+ DUT.u_bank.q1_props.fail_count + DUT.u_bank.q2_props.fail_count
			+ DUT.u_bank.q3_props.fail_count;
		$display("Errors: %0d value mismatches, %0d timeouts, %0d assertion failures",
			errors, timeouts, assert_fails);
		if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/packet_vectors.mem
// queue_sel payload slots(newest slot in low bits) occupancy drop_digits(tens ones)
// One packet per line, a queue_sel of f ends the list
1 2 3fffa 1 00
2 0 3fff8 1 00
2 1 3ffc1 2 00
2 2 3fe0a 3 00
2 3 3f053 4 00
2 0 38298 5 00
2 1 014c1 6 00
2 3 0a60b 6 01
2 2 1305a 6 02
0 3 3fffb 1 00
3 0 3fff8 1 00
1 1 3ffd1 2 00
f 0 00000 0 00

//--- all.f
src/link_pkg.sv
src/buffer_pkg.sv
src/packet_receiver.sv
src/buffer_bank.sv
src/drop_statistics.sv
src/packet_switch_top.sv
verification/packet_switch_assert.sv
verification/tb_clock_gen.sv
verification/tb_packet_switch.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_packet_switch
BUILD_DIR ?= obj_dir
FILE_LIST ?= all.f
VFLAGS ?= --binary --timing --assert -j 0
SIM_ARGS ?= +verilator+error+limit+1000
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
